/* src/npc_pkg.sv */
`default_nettype none

package npc_pkg;

    localparam int ADDR_WIDTH = 30;
    localparam int IDX_WIDTH  = 8;
    localparam int STACK_LEN  = 16;
    localparam int PTR_WIDTH  = 4;

    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 30'h0700_0000;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [IDX_WIDTH-1:0]  idx_t;
    // high bit set selects the btb for returns
    typedef logic [1:0]            choice_t;

    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } branch_kind_e;

    // resolution record from execute, valid for one cycle
    typedef struct packed {
        logic         update_en;
        logic         mis_pdc;
        branch_kind_e kind_ex;
        addr_t        pc_ex;
        addr_t        npc_ex;
        addr_t        ret_pc_ex;
        logic         choice_real;
        choice_t      choice_pdch_ex;
    } ex_update_t;

    // predecode and direction info for the current packet
    typedef struct packed {
        logic         stall;
        logic         taken_pdc;
        branch_kind_e kind_pdc;
    } pdc_info_t;

    // btb index folds two address bytes together
    function automatic idx_t btb_hash(input addr_t addr);
        return addr[IDX_WIDTH-1:0] ^ addr[2*IDX_WIDTH-1:IDX_WIDTH];
    endfunction

    function automatic idx_t cpht_hash(input addr_t addr);
        return addr[IDX_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* src/btb.sv */
`timescale 1ns/1ns
`default_nettype none

module btb import npc_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  idx_t  rd_idx,
    output logic  hit,
    output addr_t target,
    input  logic  wr_en,
    input  idx_t  wr_idx,
    input  addr_t wr_target
);

    logic [2**IDX_WIDTH-1:0] valid;
    addr_t                   targets [2**IDX_WIDTH];

    // lookup is combinational, same cycle as pc
    assign hit    = valid[rd_idx];
    assign target = targets[rd_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            targets[wr_idx] <= wr_target;
        end
    end

endmodule

`default_nettype wire

/* src/ras.sv */
`timescale 1ns/1ns
`default_nettype none

module ras import npc_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  push,
    input  logic  pop_commit,
    input  logic  pop_spec,
    input  logic  resync,
    input  addr_t push_addr,
    output addr_t top
);

    logic [PTR_WIDTH-1:0] commit_ptr;
    logic [PTR_WIDTH-1:0] commit_nxt;
    logic [PTR_WIDTH-1:0] spec_ptr;
    addr_t                stack [STACK_LEN];

    // committed pointer moves only on resolved calls and returns
    always_comb begin
        commit_nxt = commit_ptr;
        if (push) begin
            commit_nxt = commit_ptr + PTR_WIDTH'(1);
        end else if (pop_commit) begin
            commit_nxt = commit_ptr - PTR_WIDTH'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            commit_ptr <= '0;
            spec_ptr   <= '0;
        end else begin
            commit_ptr <= commit_nxt;
            // any update repairs the speculative pointer
            if (resync) begin
                spec_ptr <= commit_nxt;
            end else if (pop_spec) begin
                spec_ptr <= spec_ptr - PTR_WIDTH'(1);
            end
        end
    end

    // circular buffer, wraps modulo the depth
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < STACK_LEN; i++) begin
                stack[i] <= '0;
            end
        end else if (push) begin
            stack[commit_nxt] <= push_addr;
        end
    end

    assign top = stack[spec_ptr];

endmodule

`default_nettype wire

/* src/cpht.sv */
`timescale 1ns/1ns
`default_nettype none

module cpht import npc_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  idx_t    rd_idx,
    output choice_t choice,
    input  logic    wr_en,
    input  idx_t    wr_idx,
    input  logic    choice_real,
    input  choice_t choice_old
);

    choice_t counters [2**IDX_WIDTH];
    choice_t choice_new;

    assign choice = counters[rd_idx];

    // train from the value seen at prediction time, not the current entry
    always_comb begin
        if (choice_real) begin
            if (choice_old == 2'b11) begin
                choice_new = 2'b11;
            end else begin
                choice_new = choice_old + 2'd1;
            end
        end else begin
            if (choice_old == 2'b00) begin
                choice_new = 2'b00;
            end else begin
                choice_new = choice_old - 2'd1;
            end
        end
    end

    // weakly prefer the ras out of reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**IDX_WIDTH; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (wr_en) begin
            counters[wr_idx] <= choice_new;
        end
    end

endmodule

`default_nettype wire

/* src/npc_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module npc_predictor import npc_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  pdc_info_t  pdc,
    input  ex_update_t ex,
    input  addr_t      pc,
    input  idx_t       btb_idx,
    input  idx_t       cpht_idx,
    output addr_t      npc_pdc,
    output logic       choice_btb_ras,
    output choice_t    choice_pdch
);

    logic  btb_hit;
    addr_t btb_target;
    addr_t ras_top;
    addr_t seq_pc;
    addr_t btb_npc;
    logic  ret_pdc;

    assign ret_pdc = !pdc.stall && pdc.taken_pdc && (pdc.kind_pdc == RET);

    btb u_btb (
        .clk       (clk),
        .rstn      (rstn),
        .rd_idx    (btb_idx),
        .hit       (btb_hit),
        .target    (btb_target),
        .wr_en     (ex.update_en && (ex.kind_ex != NOT_JUMP)),
        .wr_idx    (btb_hash(ex.pc_ex)),
        .wr_target (ex.npc_ex)
    );

    // speculative pop only when no update is resyncing the pointers
    ras u_ras (
        .clk        (clk),
        .rstn       (rstn),
        .push       (ex.update_en && (ex.kind_ex == CALL)),
        .pop_commit (ex.update_en && (ex.kind_ex == RET)),
        .pop_spec   (!ex.update_en && ret_pdc),
        .resync     (ex.update_en),
        .push_addr  (ex.ret_pc_ex),
        .top        (ras_top)
    );

    cpht u_cpht (
        .clk         (clk),
        .rstn        (rstn),
        .rd_idx      (cpht_idx),
        .choice      (choice_pdch),
        .wr_en       (ex.update_en && (ex.kind_ex == RET)),
        .wr_idx      (cpht_hash(ex.pc_ex)),
        .choice_real (ex.choice_real),
        .choice_old  (ex.choice_pdch_ex)
    );

    assign choice_btb_ras = choice_pdch[1];

    // fetch packets are two words, odd address finishes the packet
    assign seq_pc  = pc[0] ? pc + ADDR_WIDTH'(1) : pc + ADDR_WIDTH'(2);
    assign btb_npc = btb_hit ? btb_target : seq_pc;

    always_comb begin
        if (pdc.stall) begin
            npc_pdc = pc;
        end else if (!pdc.taken_pdc) begin
            npc_pdc = seq_pc;
        end else begin
            case (pdc.kind_pdc)
                DIRECT_JUMP, INDIRECT_JUMP, JUMP, CALL: npc_pdc = btb_npc;
                RET:     npc_pdc = choice_btb_ras ? btb_npc : ras_top;
                default: npc_pdc = seq_pc;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_gen import npc_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  addr_t npc_pdc,
    input  logic  redirect,
    input  addr_t npc_ex,
    output addr_t pc,
    output idx_t  btb_idx,
    output idx_t  cpht_idx
);

    addr_t pc_q;

    // a resolved misprediction overrides the prediction
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            pc_q <= npc_ex;
        end else begin
            pc_q <= npc_pdc;
        end
    end

    assign pc = pc_q;

    // table indices from the current fetch pc
    assign btb_idx  = btb_hash(pc_q);
    assign cpht_idx = cpht_hash(pc_q);

endmodule

`default_nettype wire

/* src/fetch_npc.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_npc import npc_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  pdc_info_t  pdc,
    input  ex_update_t ex,
    output addr_t      pc,
    output addr_t      npc_pdc,
    output logic       choice_btb_ras,
    output choice_t    choice_pdch
);

    idx_t btb_idx;
    idx_t cpht_idx;
    logic redirect;

    assign redirect = ex.update_en && ex.mis_pdc;

    pc_gen u_pc_gen (
        .clk      (clk),
        .rstn     (rstn),
        .npc_pdc  (npc_pdc),
        .redirect (redirect),
        .npc_ex   (ex.npc_ex),
        .pc       (pc),
        .btb_idx  (btb_idx),
        .cpht_idx (cpht_idx)
    );

    npc_predictor u_npc_predictor (
        .clk            (clk),
        .rstn           (rstn),
        .pdc            (pdc),
        .ex             (ex),
        .pc             (pc),
        .btb_idx        (btb_idx),
        .cpht_idx       (cpht_idx),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras),
        .choice_pdch    (choice_pdch)
    );

endmodule

`default_nettype wire

/* verification/fetch_npc_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_npc_assertions import npc_pkg::*; (
    input logic       clk,
    input logic       rstn,
    input pdc_info_t  pdc,
    input ex_update_t ex,
    input addr_t      pc,
    input addr_t      npc_pdc,
    input logic       choice_btb_ras,
    input choice_t    choice_pdch
);

    // a stalled packet holds its fetch pc
    stall_holds_pc: assert property (@(posedge clk) disable iff (!rstn)
        (pdc.stall && !(ex.update_en && ex.mis_pdc)) |=> (pc == $past(pc)))
        else $error("pc moved while the packet was stalled");

    // strong btb training on a return reads back at the same choice index
    trained_ret_prefers_btb: assert property (@(posedge clk) disable iff (!rstn)
        (ex.update_en && (ex.kind_ex == RET) && ex.choice_real && ex.choice_pdch_ex[1])
        |=> (pc[IDX_WIDTH-1:0] != $past(ex.pc_ex[IDX_WIDTH-1:0]))
            || (choice_btb_ras && (choice_pdch == 2'b11)))
        else $error("trained return counter does not select the btb");

    // resolved misprediction wins on the next edge
    redirect_lands: assert property (@(posedge clk) disable iff (!rstn)
        (ex.update_en && ex.mis_pdc) |=> (pc == $past(ex.npc_ex)))
        else $error("pc did not follow the redirect target");

endmodule

bind npc_predictor fetch_npc_assertions u_fetch_npc_assertions (
    .clk            (clk),
    .rstn           (rstn),
    .pdc            (pdc),
    .ex             (ex),
    .pc             (pc),
    .npc_pdc        (npc_pdc),
    .choice_btb_ras (choice_btb_ras),
    .choice_pdch    (choice_pdch)
);

`default_nettype wire

/* verification/tb_fetch_npc.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_npc import npc_pkg::*; ();

    typedef struct packed {
        logic pc;
        logic npc;
        logic choice;
    } chk_t;

    typedef struct packed {
        pdc_info_t  pdc;
        ex_update_t ex;
        chk_t       chk;
    } step_t;

    logic       clk;
    logic       rstn;
    pdc_info_t  pdc;
    ex_update_t ex;
    addr_t      pc;
    addr_t      npc_pdc;
    logic       choice_btb_ras;
    choice_t    choice_pdch;

    step_t      steps [$];
    pdc_info_t  no_pdc;
    ex_update_t no_update;

    // reference model of pc, btb, counters and ras
    addr_t      m_pc;
    logic       m_valid [256];
    addr_t      m_target [256];
    choice_t    m_count [256];
    addr_t      m_stack [16];
    logic [3:0] m_commit;
    logic [3:0] m_spec;

    fetch_npc u_fetch_npc (
        .clk            (clk),
        .rstn           (rstn),
        .pdc            (pdc),
        .ex             (ex),
        .pc             (pc),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras),
        .choice_pdch    (choice_pdch)
    );

    always #2 clk = ~clk;

    initial begin
        #20000;
        $display("timeout: the run did not reach its end in time");
        abort_run();
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_choice(input string name, input choice_t got, input choice_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic idx_t fold_btb_index(input addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic idx_t choice_index(input addr_t a);
        return a[7:0];
    endfunction

    function automatic pdc_info_t predecode(input logic stall, input logic taken,
                                            input branch_kind_e kind);
        pdc_info_t p;
        p.stall     = stall;
        p.taken_pdc = taken;
        p.kind_pdc  = kind;
        return p;
    endfunction

    function automatic ex_update_t resolve(input logic mis, input branch_kind_e kind,
                                           input addr_t pc_ex, input addr_t npc_ex,
                                           input addr_t ret_pc, input logic real_btb,
                                           input choice_t old);
        ex_update_t e;
        e.update_en      = 1'b1;
        e.mis_pdc        = mis;
        e.kind_ex        = kind;
        e.pc_ex          = pc_ex;
        e.npc_ex         = npc_ex;
        e.ret_pc_ex      = ret_pc;
        e.choice_real    = real_btb;
        e.choice_pdch_ex = old;
        return e;
    endfunction

    function automatic addr_t predict_npc(input pdc_info_t p);
        addr_t seq;
        addr_t via_btb;
        idx_t  bi;
        seq     = m_pc[0] ? m_pc + 30'd1 : m_pc + 30'd2;
        bi      = fold_btb_index(m_pc);
        via_btb = m_valid[bi] ? m_target[bi] : seq;
        if (p.stall) begin
            return m_pc;
        end
        if (!p.taken_pdc) begin
            return seq;
        end
        case (p.kind_pdc)
            DIRECT_JUMP, INDIRECT_JUMP, JUMP, CALL: return via_btb;
            RET:     return m_count[choice_index(m_pc)][1] ? via_btb : m_stack[m_spec];
            default: return seq;
        endcase
    endfunction

    task automatic reset_model();
        m_pc     = RESET_PC;
        m_commit = 4'd0;
        m_spec   = 4'd0;
        for (int i = 0; i < 256; i++) begin
            m_valid[i]  = 1'b0;
            m_target[i] = '0;
            m_count[i]  = 2'b01;
        end
        for (int i = 0; i < 16; i++) begin
            m_stack[i] = '0;
        end
    endtask

    // mirrors what the dut does at the coming clock edge
    task automatic model_edge(input pdc_info_t p, input ex_update_t e, input addr_t pred);
        idx_t ci;
        ci = choice_index(e.pc_ex);
        if (e.update_en) begin
            if (e.kind_ex != NOT_JUMP) begin
                m_valid[fold_btb_index(e.pc_ex)]  = 1'b1;
                m_target[fold_btb_index(e.pc_ex)] = e.npc_ex;
            end
            if (e.kind_ex == RET && e.choice_real) begin
                m_count[ci] = (e.choice_pdch_ex == 2'd3) ? 2'd3 : e.choice_pdch_ex + 2'd1;
            end else if (e.kind_ex == RET) begin
                m_count[ci] = (e.choice_pdch_ex == 2'd0) ? 2'd0 : e.choice_pdch_ex - 2'd1;
            end
            if (e.kind_ex == CALL) begin
                m_commit          = m_commit + 4'd1;
                m_stack[m_commit] = e.ret_pc_ex;
            end else if (e.kind_ex == RET) begin
                m_commit = m_commit - 4'd1;
            end
            m_spec = m_commit;
        end else if (!p.stall && p.taken_pdc && p.kind_pdc == RET) begin
            m_spec = m_spec - 4'd1;
        end
        m_pc = (e.update_en && e.mis_pdc) ? e.npc_ex : pred;
    endtask

    task automatic add_step(input pdc_info_t p, input ex_update_t e, input chk_t c);
        step_t s;
        s.pdc = p;
        s.ex  = e;
        s.chk = c;
        steps.push_back(s);
    endtask

    task automatic build_directed();
        no_pdc    = '0;
        no_update = '0;
        // reset value, then sequential stepping from an odd address
        repeat (3) add_step(no_pdc, no_update, 3'b111);
        add_step(no_pdc, resolve(1'b1, NOT_JUMP, '0, 30'h0100_0001, '0, 1'b0, 2'b00), 3'b100);
        repeat (3) add_step(no_pdc, no_update, 3'b111);
        // btb miss, training update, then a hit at the same pc
        add_step(no_pdc, resolve(1'b1, NOT_JUMP, '0, 30'h0000_1230, '0, 1'b0, 2'b00), 3'b100);
        add_step(predecode(1'b0, 1'b1, DIRECT_JUMP), no_update, 3'b111);
        add_step(no_pdc, resolve(1'b1, DIRECT_JUMP, 30'h0000_1230, 30'h0000_4560, '0, 1'b0,
                                 2'b00), 3'b111);
        add_step(no_pdc, resolve(1'b1, NOT_JUMP, '0, 30'h0000_1230, '0, 1'b0, 2'b00), 3'b111);
        add_step(predecode(1'b0, 1'b1, DIRECT_JUMP), no_update, 3'b111);
        repeat (2) add_step(predecode(1'b1, 1'b1, JUMP), no_update, 3'b111);
        // call pushes its return address, a taken ret reads it back
        add_step(no_pdc, resolve(1'b0, CALL, 30'h0000_3000, 30'h0000_5000, 30'h0000_3002,
                                 1'b0, 2'b00), 3'b111);
        add_step(predecode(1'b0, 1'b1, RET), no_update, 3'b111);
        add_step(no_pdc, no_update, 3'b111);
        // two returns where the btb was right push the counter to 3
        add_step(no_pdc, resolve(1'b0, RET, 30'h0000_6000, 30'h0000_7000, '0, 1'b1, 2'b01),
                 3'b111);
        add_step(no_pdc, resolve(1'b0, RET, 30'h0000_6000, 30'h0000_7000, '0, 1'b1, 2'b10),
                 3'b111);
        add_step(no_pdc, resolve(1'b1, NOT_JUMP, '0, 30'h0000_6000, '0, 1'b0, 2'b00), 3'b111);
        add_step(predecode(1'b0, 1'b1, RET), no_update, 3'b111);
        // mispredict after a speculative pop restores the ras top
        add_step(no_pdc, resolve(1'b1, CALL, 30'h0000_8002, 30'h0000_b010, 30'h0000_8004,
                                 1'b0, 2'b00), 3'b111);
        add_step(predecode(1'b0, 1'b1, RET), no_update, 3'b111);
        add_step(no_pdc, resolve(1'b1, NOT_JUMP, '0, 30'h0000_a010, '0, 1'b0, 2'b00), 3'b111);
        add_step(predecode(1'b0, 1'b1, RET), no_update, 3'b111);
        add_step(no_pdc, no_update, 3'b111);
    endtask

    task automatic build_random(input int n);
        pdc_info_t  p;
        ex_update_t e;
        for (int i = 0; i < n; i++) begin
            p.stall     = ($urandom % 8) == 0;
            p.taken_pdc = 1'($urandom % 2);
            p.kind_pdc  = branch_kind_e'(3'($urandom % 8));
            e = '0;
            // small address pool so the tables see repeated hits
            if ($urandom % 3 == 0) begin
                e = resolve(1'($urandom % 2), branch_kind_e'(3'($urandom % 8)),
                            30'h1000 + addr_t'($urandom % 64),
                            30'h1000 + addr_t'($urandom % 64),
                            30'h2000 + addr_t'($urandom % 64),
                            1'($urandom % 2), 2'($urandom % 4));
            end
            add_step(p, e, 3'b111);
        end
    endtask

    task automatic hold_reset();
        int cycles;
        cycles = 0;
        rstn   = 1'b0;
        while (pc !== RESET_PC) begin
            if (cycles == 16) begin
                $display("pc did not take its reset value while rstn was low");
                abort_run();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        while (cycles < 16) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        rstn = 1'b1;
    endtask

    task automatic apply_steps();
        addr_t   exp_npc;
        choice_t exp_choice;
        foreach (steps[i]) begin
            pdc = steps[i].pdc;
            ex  = steps[i].ex;
            #2;
            exp_npc    = predict_npc(steps[i].pdc);
            exp_choice = m_count[choice_index(m_pc)];
            if (steps[i].chk.pc) begin
                check_addr("pc", pc, m_pc);
            end
            if (steps[i].chk.npc) begin
                check_addr("npc_pdc", npc_pdc, exp_npc);
            end
            if (steps[i].chk.choice) begin
                check_choice("choice_pdch", choice_pdch, exp_choice);
                check_bit("choice_btb_ras", choice_btb_ras, exp_choice[1]);
            end
            model_edge(steps[i].pdc, steps[i].ex, exp_npc);
            @(posedge clk);
            #1;
        end
        pdc = '0;
        ex  = '0;
    endtask

    initial begin
        clk  = 1'b0;
        rstn = 1'b0;
        pdc  = '0;
        ex   = '0;
        void'($urandom(32'h28791a2b));
        reset_model();
        build_directed();
        build_random(60);
        hold_reset();
        apply_steps();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_npc.f */
src/npc_pkg.sv
src/btb.sv
src/ras.sv
src/cpht.sv
src/npc_predictor.sv
src/pc_gen.sv
src/fetch_npc.sv
verification/fetch_npc_assertions.sv
verification/tb_fetch_npc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_npc
FILELIST  ?= fetch_npc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
